/* src/apb_bus_pkg.sv */
//////////////////////////////////////////////////////////////////////
// APB4 bus definitions shared by the protocol monitor
// Holds the bus widths, the field types and the request struct that
// groups every signal which must stay stable during a transfer
// Reference the contents with scoped names, e.g. apb_bus_pkg::paddr_t
//////////////////////////////////////////////////////////////////////

`default_nettype none

package apb_bus_pkg;

  // Bus widths
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  // One strobe per byte lane
  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  // Field types
  typedef logic [ADDR_WIDTH-1:0] paddr_t;
  typedef logic [DATA_WIDTH-1:0] pdata_t;
  typedef logic [STRB_WIDTH-1:0] pstrb_t;
  typedef logic [2:0]            pprot_t;

  // Request fields that are held for the whole transfer
  typedef struct packed {
    paddr_t paddr;
    logic   pwrite;
    pstrb_t pstrb;
    pprot_t pprot;
    pdata_t pwdata;
  } apb_req_t;

endpackage

`default_nettype wire

/* src/apb_check_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Rule definitions for the APB4 protocol monitor
// Every checked rule owns one bit of the violation vector, and the
// enum gives the bit position of each rule
// Also holds the widths of the error counter and the watchdog counter
//////////////////////////////////////////////////////////////////////

`default_nettype none

package apb_check_pkg;

  // Rule indices, bit positions in violation_vec_t
  typedef enum logic [3:0] {
    psel_drop             = 4'd0,
    penable_in_setup      = 4'd1,
    penable_low_in_access = 4'd2,
    paddr_unstable        = 4'd3,
    pwrite_unstable       = 4'd4,
    pstrb_unstable        = 4'd5,
    pprot_unstable        = 4'd6,
    pwdata_unstable       = 4'd7,
    paddr_misaligned      = 4'd8,
    pstrb_on_read         = 4'd9,
    pstrb_irregular       = 4'd10,
    watchdog_expired      = 4'd11
  } violation_e;

  localparam int NUM_VIOLATIONS = 12;

  // One bit per rule
  typedef logic [NUM_VIOLATIONS-1:0] violation_vec_t;

  // Saturating error count and watchdog down-counter
  typedef logic [15:0] viol_count_t;
  typedef logic [15:0] wdog_count_t;

endpackage

`default_nettype wire

/* src/apb_phase_tracker.sv */
//////////////////////////////////////////////////////////////////////
// APB transfer phase tracker
// Keeps a one-cycle copy of the bus and derives setup, access and
// in-transfer state, so the rule checks only compare against these
// All outputs except access_phase are combinational from the registers
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module apb_phase_tracker (
  input  wire logic                  PCLK,
  input  wire logic                  PRESETn,
  input  wire logic                  psel,
  input  wire logic                  penable,
  input  wire logic                  pready,
  input  wire apb_bus_pkg::apb_req_t bus_req,
  output apb_bus_pkg::apb_req_t      prev_req,
  output logic                       setup_phase,
  output logic                       access_phase,
  output logic                       in_transfer,
  output logic                       completing
);

  // Control signals of the previous cycle
  logic prev_psel;
  logic prev_penable;
  logic prev_pready;
  logic prev_completing;

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      prev_psel    <= 1'b0;
      prev_penable <= 1'b0;
      prev_pready  <= 1'b0;
    end
    else
    begin
      prev_psel    <= psel;
      prev_penable <= penable;
      prev_pready  <= pready;
    end
  end

  // Request copy, payload only
  always_ff @(posedge PCLK)
  begin
    prev_req <= bus_req;
  end

  // Transfer ends when slave accepts the access phase
  assign completing      = psel & penable & pready;
  assign prev_completing = prev_psel & prev_penable & prev_pready;

  // New transfer starts after idle or right after a completion
  assign setup_phase = psel & (~prev_psel | prev_completing);

  // Transfer still open from last cycle
  assign in_transfer = prev_psel & ~prev_completing;

  // Access phase follows setup and lasts until PREADY
  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
      access_phase <= 1'b0;
    else if (setup_phase)
      access_phase <= 1'b1;
    else if (pready)
      access_phase <= 1'b0;
  end

endmodule

`default_nettype wire

/* src/apb_rule_checks.sv */
//////////////////////////////////////////////////////////////////////
// APB4 bus rule evaluation
// Purely combinational: compares the current bus cycle with the
// phase state and the previous request and raises one bit per rule
// The watchdog bit is left low here and merged in the status block
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module apb_rule_checks (
  input  wire logic                  psel,
  input  wire logic                  penable,
  input  wire logic                  setup_phase,
  input  wire logic                  access_phase,
  input  wire logic                  in_transfer,
  input  wire apb_bus_pkg::apb_req_t bus_req,
  input  wire apb_bus_pkg::apb_req_t prev_req,
  output apb_check_pkg::violation_vec_t violations
);

  localparam int STRB_W    = apb_bus_pkg::STRB_WIDTH;
  // Address bits that select a byte within one data word
  localparam int LANE_BITS = $clog2(STRB_W);

  // Stability checks apply once a transfer has been running
  logic hold_check;
  logic strb_block;

  //////////////////////////////////////////////////////////////////////
  // Strobe shape
  //////////////////////////////////////////////////////////////////////

  // True when strb is exactly 1, 2, 4 .. lanes wide and starts on a
  // multiple of its own width
  function automatic logic strb_is_block(input apb_bus_pkg::pstrb_t strb);
    apb_bus_pkg::pstrb_t mask;
    logic                hit;
    hit = 1'b0;
    for (int size = 1; size <= STRB_W; size = size * 2)
    begin
      for (int base = 0; base < STRB_W; base = base + size)
      begin
        // size ones, shifted up to the block start
        mask = ({STRB_W{1'b1}} >> (STRB_W - size)) << base;
        hit  = hit | (strb == mask);
      end
    end
    return hit;
  endfunction

  assign hold_check = psel & in_transfer;
  assign strb_block = strb_is_block(bus_req.pstrb);

  //////////////////////////////////////////////////////////////////////
  // Rule vector
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    violations = '0;

    // Select and enable sequencing
    violations[apb_check_pkg::psel_drop]             = ~psel & in_transfer;
    violations[apb_check_pkg::penable_in_setup]      = setup_phase & penable;
    violations[apb_check_pkg::penable_low_in_access] = access_phase & ~penable;

    // Request fields must hold until completion
    violations[apb_check_pkg::paddr_unstable]  =
      hold_check & (bus_req.paddr != prev_req.paddr);
    violations[apb_check_pkg::pwrite_unstable] =
      hold_check & (bus_req.pwrite != prev_req.pwrite);
    violations[apb_check_pkg::pstrb_unstable]  =
      hold_check & (bus_req.pstrb != prev_req.pstrb);
    violations[apb_check_pkg::pprot_unstable]  =
      hold_check & (bus_req.pprot != prev_req.pprot);
    // Write data only matters on writes
    violations[apb_check_pkg::pwdata_unstable] =
      hold_check & bus_req.pwrite & (bus_req.pwdata != prev_req.pwdata);

    // Word alignment of the address
    violations[apb_check_pkg::paddr_misaligned] =
      psel & (bus_req.paddr[LANE_BITS-1:0] != '0);

    // Strobes are a write-only qualifier
    violations[apb_check_pkg::pstrb_on_read] =
      psel & ~bus_req.pwrite & (bus_req.pstrb != '0);
    violations[apb_check_pkg::pstrb_irregular] =
      psel & (bus_req.pstrb != '0) & ~strb_block;

    // Watchdog bit comes from apb_watchdog
    violations[apb_check_pkg::watchdog_expired] = 1'b0;
  end

endmodule

`default_nettype wire

/* src/apb_watchdog.sv */
//////////////////////////////////////////////////////////////////////
// APB transfer watchdog
// Down-counter loaded with WATCHDOG_TIMEOUT while the bus is idle or
// a transfer completes; expired stays high while it sits at zero
// A WATCHDOG_TIMEOUT of 0 turns the watchdog off
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module apb_watchdog #(
  parameter int WATCHDOG_TIMEOUT = 128
) (
  input  wire logic PCLK,
  input  wire logic PRESETn,
  input  wire logic psel,
  input  wire logic completing,
  output logic      expired
);

  localparam apb_check_pkg::wdog_count_t RELOAD =
    apb_check_pkg::wdog_count_t'(WATCHDOG_TIMEOUT);

  apb_check_pkg::wdog_count_t count;

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
      count <= RELOAD;
    else if (!psel || completing)
      count <= RELOAD;
    // Hold at zero until the transfer ends
    else if (count != '0)
      count <= count - 1'b1;
  end

  assign expired = (WATCHDOG_TIMEOUT != 0) && (count == '0);

endmodule

`default_nettype wire

/* src/apb_error_status.sv */
//////////////////////////////////////////////////////////////////////
// Monitor configuration and status
// Masks the rule hits with enable_mask, keeps sticky flags and a
// saturating hit count, and drives a level interrupt from the flags
// clear_flags is a single-cycle pulse, hits on that edge still count
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module apb_error_status (
  input  wire logic                          PCLK,
  input  wire logic                          PRESETn,
  input  wire logic                          clear_flags,
  input  wire logic                          expired,
  input  wire apb_check_pkg::violation_vec_t violations,
  input  wire apb_check_pkg::violation_vec_t enable_mask,
  output apb_check_pkg::violation_vec_t      error_flags,
  output apb_check_pkg::viol_count_t         error_count,
  output logic                               error_irq
);

  apb_check_pkg::violation_vec_t hits;
  apb_check_pkg::viol_count_t    count_base;

  // Watchdog level joins its rule bit, then the enable mask applies
  always_comb
  begin
    hits = violations;
    hits[apb_check_pkg::watchdog_expired] =
      hits[apb_check_pkg::watchdog_expired] | expired;
    hits = hits & enable_mask;
  end

  // Count restarts from zero on a clear
  assign count_base = clear_flags ? '0 : error_count;

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      error_flags <= '0;
      error_count <= '0;
    end
    else
    begin
      // Sticky, only a clear drops a flag
      if (clear_flags)
        error_flags <= hits;
      else
        error_flags <= error_flags | hits;
      // One step per edge with any enabled hit, stops at all ones
      if ((hits != '0) && (count_base != '1))
        error_count <= count_base + 1'b1;
      else
        error_count <= count_base;
    end
  end

  assign error_irq = |error_flags;

endmodule

`default_nettype wire

/* src/apb_protocol_monitor.sv */
//////////////////////////////////////////////////////////////////////
// APB4 protocol monitor, top level
// Passive observer of one APB4 bus; rule hits are recorded as sticky
// flags one cycle after the offending edge
// Set WATCHDOG_TIMEOUT to the longest legal transfer, 0 disables it
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module apb_protocol_monitor #(
  parameter int WATCHDOG_TIMEOUT = 128
) (
  input  wire logic                          PCLK,
  input  wire logic                          PRESETn,
  input  wire logic                          PSEL,
  input  wire logic                          PENABLE,
  input  wire logic                          PWRITE,
  input  wire logic                          PREADY,
  input  wire apb_bus_pkg::paddr_t           PADDR,
  input  wire apb_bus_pkg::pstrb_t           PSTRB,
  input  wire apb_bus_pkg::pprot_t           PPROT,
  input  wire apb_bus_pkg::pdata_t           PWDATA,
  input  wire apb_check_pkg::violation_vec_t enable_mask,
  input  wire logic                          clear_flags,
  output apb_check_pkg::violation_vec_t      error_flags,
  output apb_check_pkg::viol_count_t         error_count,
  output logic                               error_irq
);

  apb_bus_pkg::apb_req_t         bus_req;
  apb_bus_pkg::apb_req_t         prev_req;
  apb_check_pkg::violation_vec_t violations;
  logic                          setup_phase;
  logic                          access_phase;
  logic                          in_transfer;
  logic                          completing;
  logic                          expired;

  // Fields that must hold for the whole transfer
  assign bus_req = '{paddr: PADDR, pwrite: PWRITE, pstrb: PSTRB,
                     pprot: PPROT, pwdata: PWDATA};

  apb_phase_tracker apb_phase_tracker_inst (
    .PCLK         (PCLK),
    .PRESETn      (PRESETn),
    .psel         (PSEL),
    .penable      (PENABLE),
    .pready       (PREADY),
    .bus_req      (bus_req),
    .prev_req     (prev_req),
    .setup_phase  (setup_phase),
    .access_phase (access_phase),
    .in_transfer  (in_transfer),
    .completing   (completing)
  );

  apb_rule_checks apb_rule_checks_inst (
    .psel         (PSEL),
    .penable      (PENABLE),
    .setup_phase  (setup_phase),
    .access_phase (access_phase),
    .in_transfer  (in_transfer),
    .bus_req      (bus_req),
    .prev_req     (prev_req),
    .violations   (violations)
  );

  apb_watchdog #(
    .WATCHDOG_TIMEOUT (WATCHDOG_TIMEOUT)
  ) apb_watchdog_inst (
    .PCLK       (PCLK),
    .PRESETn    (PRESETn),
    .psel       (PSEL),
    .completing (completing),
    .expired    (expired)
  );

  apb_error_status apb_error_status_inst (
    .PCLK        (PCLK),
    .PRESETn     (PRESETn),
    .clear_flags (clear_flags),
    .expired     (expired),
    .violations  (violations),
    .enable_mask (enable_mask),
    .error_flags (error_flags),
    .error_count (error_count),
    .error_irq   (error_irq)
  );

endmodule

`default_nettype wire

/* testbench/apb_monitor_properties.sv */
//////////////////////////////////////////////////////////////////////
// Concurrent assertions for the APB4 protocol monitor
// Bound to apb_protocol_monitor, watches the status outputs and the
// phase signals of the tracker
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module apb_monitor_properties (
  input wire logic                          PCLK,
  input wire logic                          PRESETn,
  input wire logic                          clear_flags,
  input wire logic                          setup_phase,
  input wire logic                          access_phase,
  input wire apb_check_pkg::violation_vec_t error_flags,
  input wire logic                          error_irq
);

  // Interrupt is the OR of all flags
  irq_matches_flags: assert property (@(posedge PCLK) disable iff (!PRESETn)
    error_irq == (|error_flags))
    else $error("error_irq differs from the OR of error_flags");

  // Flags are sticky until a clear pulse
  flags_sticky: assert property (@(posedge PCLK) disable iff (!PRESETn)
    (|($past(error_flags) & ~error_flags)) |-> $past(clear_flags))
    else $error("A flag fell without clear_flags");

  // Setup and access are exclusive
  phases_exclusive: assert property (@(posedge PCLK) disable iff (!PRESETn)
    !(setup_phase && access_phase))
    else $error("setup_phase and access_phase both high");

endmodule

bind apb_protocol_monitor apb_monitor_properties apb_monitor_properties_inst (
  .PCLK         (PCLK),
  .PRESETn      (PRESETn),
  .clear_flags  (clear_flags),
  .setup_phase  (setup_phase),
  .access_phase (access_phase),
  .error_flags  (error_flags),
  .error_irq    (error_irq)
);

`default_nettype wire

/* testbench/apb_monitor_tb.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the APB4 protocol monitor
// Drives seeded random APB transfers with injected faults and checks
// flags, count and interrupt every cycle against a cycle model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module apb_monitor_tb;

  localparam int WDOG       = 16;
  localparam int MAX_CYCLES = 200000;

  // Bus and control inputs of the DUT
  logic                          PCLK;
  logic                          PRESETn;
  logic                          psel;
  logic                          penable;
  logic                          pwrite;
  logic                          pready;
  logic                          clear_flags;
  apb_bus_pkg::paddr_t           paddr;
  apb_bus_pkg::pstrb_t           pstrb;
  apb_bus_pkg::pprot_t           pprot;
  apb_bus_pkg::pdata_t           pwdata;
  apb_check_pkg::violation_vec_t enable_mask;

  // Status outputs of the DUT
  apb_check_pkg::violation_vec_t error_flags;
  apb_check_pkg::viol_count_t    error_count;
  logic                          error_irq;

  // Model state for the previous bus cycle
  logic                          m_psel;
  logic                          m_pen;
  logic                          m_rdy;
  logic                          m_access;
  apb_bus_pkg::apb_req_t         m_req;
  int                            m_wdog;
  // Predicted status after the latest edge
  apb_check_pkg::violation_vec_t exp_flags;
  apb_check_pkg::viol_count_t    exp_count;

  // Run bookkeeping
  int   errors;
  int   test_errors;
  int   tests_run;
  int   tests_failed;
  int   cycles;
  logic checking;

  apb_protocol_monitor #(
    .WATCHDOG_TIMEOUT (WDOG)
  ) apb_protocol_monitor_inst (
    .PCLK        (PCLK),
    .PRESETn     (PRESETn),
    .PSEL        (psel),
    .PENABLE     (penable),
    .PWRITE      (pwrite),
    .PREADY      (pready),
    .PADDR       (paddr),
    .PSTRB       (pstrb),
    .PPROT       (pprot),
    .PWDATA      (pwdata),
    .enable_mask (enable_mask),
    .clear_flags (clear_flags),
    .error_flags (error_flags),
    .error_count (error_count),
    .error_irq   (error_irq)
  );

  // 10 ns clock
  always #5 PCLK = ~PCLK;

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_flags(input string name, input apb_check_pkg::violation_vec_t exp,
                             input apb_check_pkg::violation_vec_t act);
    if (exp !== act)
    begin
      $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_count(input string name, input apb_check_pkg::viol_count_t exp,
                             input apb_check_pkg::viol_count_t act);
    if (exp !== act)
    begin
      $display("ERROR t=%0t %s expected %0d got %0d", $time, name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("ERROR t=%0t %s expected %b got %b", $time, name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Cycle model
  //////////////////////////////////////////////////////////////////////

  // Legal strobe is 1, 2 or 4 adjacent lanes starting at a multiple of the width
  function automatic logic strobe_ok(input apb_bus_pkg::pstrb_t s);
    int lo;
    int n;
    lo = -1;
    n = 0;
    // Count set lanes and find the lowest one
    for (int i = 0; i < apb_bus_pkg::STRB_WIDTH; i++)
      if (s[i])
      begin
        n++;
        if (lo < 0)
          lo = i;
      end
    if (n == 0)
      return 1'b1;
    return (n == 1 || n == 2 || n == 4) && (lo % n == 0) &&
           (s == apb_bus_pkg::pstrb_t'(((1 << n) - 1) << lo));
  endfunction

  always @(posedge PCLK)
  begin : model
    apb_check_pkg::violation_vec_t v;
    apb_bus_pkg::apb_req_t         cur;
    logic                          comp;
    logic                          pcomp;
    logic                          setup;
    logic                          intr;
    logic                          hold;
    cycles++;
    if (cycles > MAX_CYCLES)
    begin
      $display("Simulation ran past its cycle limit");
      $display("CHECKS FAILED");
      $finish;
    end
    else if (!PRESETn)
    begin
      m_psel = 0;
      m_pen = 0;
      m_rdy = 0;
      m_access = 0;
      m_wdog = WDOG;
      exp_flags = '0;
      exp_count = '0;
    end
    else
    begin
      cur = '{paddr: paddr, pwrite: pwrite, pstrb: pstrb, pprot: pprot, pwdata: pwdata};
      // Phase state seen on this edge
      comp = psel && penable && pready;
      pcomp = m_psel && m_pen && m_rdy;
      setup = psel && (!m_psel || pcomp);
      intr = m_psel && !pcomp;
      hold = psel && intr;
      // Rule hits on the driven values
      v = '0;
      v[apb_check_pkg::psel_drop] = !psel && intr;
      v[apb_check_pkg::penable_in_setup] = setup && penable;
      v[apb_check_pkg::penable_low_in_access] = m_access && !penable;
      v[apb_check_pkg::paddr_unstable] = hold && cur.paddr != m_req.paddr;
      v[apb_check_pkg::pwrite_unstable] = hold && cur.pwrite != m_req.pwrite;
      v[apb_check_pkg::pstrb_unstable] = hold && cur.pstrb != m_req.pstrb;
      v[apb_check_pkg::pprot_unstable] = hold && cur.pprot != m_req.pprot;
      v[apb_check_pkg::pwdata_unstable] = hold && pwrite && cur.pwdata != m_req.pwdata;
      v[apb_check_pkg::paddr_misaligned] = psel && (paddr % 4 != 0);
      v[apb_check_pkg::pstrb_on_read] = psel && !pwrite && pstrb != 0;
      v[apb_check_pkg::pstrb_irregular] = psel && !strobe_ok(pstrb);
      v[apb_check_pkg::watchdog_expired] = (m_wdog == 0);
      v = v & enable_mask;
      // Clear drops old state but this edge's hits still land
      if (clear_flags)
      begin
        exp_flags = v;
        exp_count = (v != '0) ? apb_check_pkg::viol_count_t'(1) : '0;
      end
      else
      begin
        exp_flags = exp_flags | v;
        if (v != '0 && exp_count != '1)
          exp_count = exp_count + 1'b1;
      end
      // Watchdog counter
      if (!psel || comp)
        m_wdog = WDOG;
      else if (m_wdog != 0)
        m_wdog = m_wdog - 1;
      // Access phase register
      if (setup)
        m_access = 1;
      else if (pready)
        m_access = 0;
      m_psel = psel;
      m_pen = penable;
      m_rdy = pready;
      m_req = cur;
    end
  end

  // Outputs against the model on every falling edge
  always @(negedge PCLK)
  begin
    if (checking)
    begin
      check_flags("error_flags", exp_flags, error_flags);
      check_count("error_count", exp_count, error_count);
      check_bit("error_irq", |exp_flags, error_irq);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Fault codes are 0 none, 1 field change, 2 PSEL drop, 3 PENABLE in setup,
  // 4 misaligned, 5 strobe on read, 6 irregular strobe and 7 long stall
  task automatic run_xfer(input int fault, input int waits);
    apb_bus_pkg::paddr_t a;
    apb_bus_pkg::pstrb_t s;
    logic wr;
    int sz;
    int fld;
    // Legal defaults
    wr = 1'($urandom_range(0, 1));
    a = apb_bus_pkg::paddr_t'($urandom()) & ~apb_bus_pkg::paddr_t'(3);
    sz = 1 << $urandom_range(0, 2);
    s = wr ? apb_bus_pkg::pstrb_t'(((1 << sz) - 1) << (sz * $urandom_range(0, 4 / sz - 1)))
           : '0;
    // Fault overrides
    if (fault == 4)
      a = a | apb_bus_pkg::paddr_t'($urandom_range(1, 3));
    if (fault == 5)
    begin
      wr = 0;
      s = apb_bus_pkg::pstrb_t'($urandom_range(1, 15));
    end
    if (fault == 6)
    begin
      wr = 1;
      s = $urandom_range(0, 1) ? 4'b0101 : 4'b0110;
    end
    if (fault == 7)
      waits = 30;
    // Mid-transfer faults need at least one wait state
    if ((fault == 1 || fault == 2) && waits == 0)
      waits = 1;
    // Setup
    @(negedge PCLK);
    psel = 1;
    penable = (fault == 3);
    pready = 0;
    paddr = a;
    pwrite = wr;
    pstrb = s;
    pprot = apb_bus_pkg::pprot_t'($urandom());
    pwdata = $urandom();
    // Access
    @(negedge PCLK);
    penable = 1;
    pready = (waits == 0);
    for (int i = 0; i < waits; i++)
    begin
      if (i == 0 && fault == 1)
      begin
        fld = $urandom_range(0, 4);
        // Write data only counts on writes
        if (fld == 4 && !pwrite)
          fld = 0;
        case (fld)
          0: paddr = paddr + 4;
          1: pwrite = ~pwrite;
          2: pstrb = pstrb ^ 4'b0001;
          3: pprot = pprot ^ 3'b001;
          default: pwdata = ~pwdata;
        endcase
      end
      if (i == 0 && fault == 2)
      begin
        psel = 0;
        penable = 0;
        break;
      end
      @(negedge PCLK);
      pready = (i == waits - 1);
    end
    // Back to idle
    @(negedge PCLK);
    psel = 0;
    penable = 0;
    // A PREADY pulse after a dropped PSEL closes the access phase
    pready = (fault == 2);
    @(negedge PCLK);
    pready = 0;
  endtask

  task automatic pulse_clear();
    @(negedge PCLK);
    clear_flags = 1;
    @(negedge PCLK);
    clear_flags = 0;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (test_errors != 0)
      tests_failed++;
    $display("%s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "failed", test_errors);
    test_errors = 0;
  endtask

  task automatic wait_irq();
    for (int n = 0; n < 100 && !error_irq; n++)
      @(negedge PCLK);
    if (!error_irq)
    begin
      $display("Interrupt did not rise within 100 cycles after the stall");
      errors++;
      test_errors++;
    end
  endtask

  initial
  begin
    PCLK = 0;
    PRESETn = 0;
    psel = 0;
    penable = 0;
    pwrite = 0;
    pready = 0;
    paddr = '0;
    pstrb = '0;
    pprot = '0;
    pwdata = '0;
    clear_flags = 0;
    enable_mask = '1;
    checking = 0;
    errors = 0;
    test_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    cycles = 0;
    void'($urandom(27));
    repeat (16) @(posedge PCLK);
    @(negedge PCLK);
    PRESETn = 1;
    checking = 1;

    // Quiet bus after reset
    repeat (8) @(negedge PCLK);
    check_flags("error_flags", '0, error_flags);
    check_count("error_count", '0, error_count);
    check_bit("error_irq", 1'b0, error_irq);
    end_test("reset and idle");

    // Legal random traffic
    repeat (300) run_xfer(0, $urandom_range(0, 3));
    check_flags("error_flags", '0, error_flags);
    check_count("error_count", '0, error_count);
    end_test("legal random transfers");

    // One fault kind at a time
    for (int f = 1; f <= 7; f++)
    begin
      repeat (3) run_xfer(0, $urandom_range(0, 3));
      run_xfer(f, $urandom_range(0, 3));
      check_bit("error_irq", 1'b1, error_irq);
      pulse_clear();
      end_test($sformatf("fault kind %0d", f));
    end

    // Masked rules leave no trace
    enable_mask = '1;
    enable_mask[apb_check_pkg::paddr_misaligned] = 1'b0;
    run_xfer(4, 1);
    check_count("error_count", '0, error_count);
    enable_mask = '1;
    enable_mask[apb_check_pkg::penable_in_setup] = 1'b0;
    run_xfer(3, 2);
    check_flags("error_flags", '0, error_flags);
    check_count("error_count", '0, error_count);
    enable_mask = '1;
    end_test("enable mask");

    // Watchdog on a long stall and then a clear while idle
    run_xfer(7, 30);
    wait_irq();
    check_bit("error_flags[watchdog_expired]", 1'b1,
              error_flags[apb_check_pkg::watchdog_expired]);
    pulse_clear();
    @(negedge PCLK);
    check_flags("error_flags", '0, error_flags);
    check_count("error_count", '0, error_count);
    check_bit("error_irq", 1'b0, error_irq);
    end_test("watchdog and clear");

    $display("Tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
src/apb_bus_pkg.sv
src/apb_check_pkg.sv
src/apb_phase_tracker.sv
src/apb_rule_checks.sv
src/apb_watchdog.sv
src/apb_error_status.sv
src/apb_protocol_monitor.sv
testbench/apb_monitor_properties.sv
testbench/apb_monitor_tb.sv

/* Makefile */
# Verilator build and run for the APB4 protocol monitor testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= apb_monitor_tb
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
BIN       := $(OBJDIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJDIR)
